//--- hw/bus_watch.sv
`timescale 1ns/1ps

module bus_watch (
	input  logic                    cpuclk,
	input  logic                    f_reset,
	input  tester_pkg::dut_bus_t    dut_bus,
	input  tester_pkg::tester_cfg_t cfg,
	output tester_pkg::dut_bus_t    sample,
	output logic                    match
);

	logic [tester_pkg::sample_width-1:0] differ;

	// free-running capture of the dut pins.
	always_ff @(posedge cpuclk) begin
		if (f_reset)
			sample <= '0;
		else
			sample <= dut_bus;
	end

	assign differ = (sample ^ cfg.cmp_value) & cfg.cmp_mask; // unmasked bits never differ.
	assign match  = differ == '0;

endmodule

//--- hw/port_a_driver.sv
`timescale 1ns/1ps

module port_a_driver (
	input  logic                             cpuclk,
	input  logic                             f_reset,
	input  tester_pkg::pa_cmd_t              pa_cmd,
	input  tester_pkg::route_t               route,
	input  tester_pkg::tester_cfg_t          cfg,
	output logic [tester_pkg::pa_width-1:0] pa
);

	logic [tester_pkg::pa_width-1:0] set_mask;
	logic [tester_pkg::pa_width-1:0] reset_mask;

	always_comb begin
		set_mask   = pa_cmd.set_mask;
		reset_mask = pa_cmd.reset_mask;
		set_mask[0]   = set_mask[0] | (|(cfg.pa_trig_set & route));
		reset_mask[0] = reset_mask[0] | (|(cfg.pa_trig_reset & route));
	end

	always_ff @(posedge cpuclk) begin
		if (f_reset)
			pa <= '0;
		else
			pa <= (pa | set_mask) & ~reset_mask; // reset wins.
	end

endmodule

//--- hw/tester_pkg.sv
package tester_pkg;

	localparam int num_routes   = 4;
	localparam int atom_width   = 32;
	localparam int sample_width = 29;
	localparam int paddr_width  = 8;
	localparam int pdata_width  = 8;
	localparam int pa_width     = 8;

	// apb register map.
	typedef enum logic [paddr_width-1:0] {
		atom0         = 8'h00,
		atom1         = 8'h01,
		atom2         = 8'h02,
		atom3         = 8'h03,
		ones_set      = 8'h04,
		pa_set        = 8'h10,
		pa_reset      = 8'h11,
		pa_trig_set   = 8'h12,
		pa_trig_reset = 8'h13,
		pa_out        = 8'h14,
		sample0       = 8'h20,
		sample1       = 8'h21,
		sample2       = 8'h22,
		sample3       = 8'h23,
		cmp_load      = 8'h24,
		cmp_trig      = 8'h25,
		irq_flags     = 8'h30
	} reg_addr_e;

	// dut pins are all active high with adr in the low bits.
	typedef struct packed {
		logic        reset;
		logic        phi;
		logic        wr;
		logic        rd;
		logic        cs_xram;
		logic [7:0]  data;
		logic        cs_rom;
		logic [14:0] adr;
	} dut_bus_t;

	typedef logic [num_routes-1:0] route_t;

	typedef struct packed {
		route_t                  ones_routes;
		logic [sample_width-1:0] cmp_value;
		logic [sample_width-1:0] cmp_mask;
		route_t                  cmp_routes;
		route_t                  pa_trig_set;   // routes that set pa bit 0.
		route_t                  pa_trig_reset; // routes that clear pa bit 0.
	} tester_cfg_t;

	// single-cycle port a masks.
	typedef struct packed {
		logic [pa_width-1:0] set_mask;
		logic [pa_width-1:0] reset_mask;
	} pa_cmd_t;

endpackage

//--- hw/tester_regs.sv
`timescale 1ns/1ps

module tester_regs (
	input  logic                                cpuclk,
	input  logic                                f_reset,
	input  logic                                psel,
	input  logic                                penable,
	input  logic                                pwrite,
	input  logic [tester_pkg::paddr_width-1:0] paddr,
	input  logic [tester_pkg::pdata_width-1:0] pwdata,
	output logic [tester_pkg::pdata_width-1:0] prdata,
	output logic                                pready,
	output logic                                pslverr,
	input  tester_pkg::dut_bus_t                sample,
	input  tester_pkg::route_t                  irq_flags,
	input  logic [tester_pkg::pa_width-1:0]    pa,
	output tester_pkg::tester_cfg_t             cfg,
	output tester_pkg::pa_cmd_t                 pa_cmd,
	output tester_pkg::route_t                  irq_clear
);

	tester_pkg::reg_addr_e                 addr;
	logic                                  access;
	logic                                  wr_en;
	logic                                  addr_ok;
	logic [tester_pkg::atom_width-1:0]     atom;
	logic [tester_pkg::atom_width-1:0]     sample_word;
	tester_pkg::route_t                    atom_routes;

	assign addr   = tester_pkg::reg_addr_e'(paddr);
	assign access = psel && penable;
	assign wr_en  = access && pwrite;
	assign pready = 1'b1; // no wait states.

	assign sample_word = {{(tester_pkg::atom_width - tester_pkg::sample_width){1'b0}}, sample};
	assign atom_routes = atom[tester_pkg::num_routes-1:0];

	// read mux and offset decode.
	always_comb begin
		prdata  = '0;
		addr_ok = 1'b1;
		case (addr)
		tester_pkg::atom0, tester_pkg::atom1, tester_pkg::atom2, tester_pkg::atom3:
			prdata = atom[8*paddr[1:0] +: 8];
		tester_pkg::sample0, tester_pkg::sample1, tester_pkg::sample2, tester_pkg::sample3:
			prdata = sample_word[8*paddr[1:0] +: 8];
		tester_pkg::pa_out:
			prdata = pa;
		tester_pkg::irq_flags:
			prdata = {{(tester_pkg::pdata_width - tester_pkg::num_routes){1'b0}}, irq_flags};
		tester_pkg::ones_set, tester_pkg::pa_set, tester_pkg::pa_reset,
		tester_pkg::pa_trig_set, tester_pkg::pa_trig_reset,
		tester_pkg::cmp_load, tester_pkg::cmp_trig:
			prdata = '0; // write only.
		default:
			addr_ok = 1'b0;
		endcase
	end

	assign pslverr = access && !addr_ok;

	always_ff @(posedge cpuclk) begin
		if (f_reset) begin
			atom <= '0;
			cfg  <= '0;
		end else if (wr_en) begin
			case (addr)
			tester_pkg::atom0, tester_pkg::atom1, tester_pkg::atom2, tester_pkg::atom3:
				atom[8*paddr[1:0] +: 8] <= pwdata;
			tester_pkg::ones_set:
				cfg.ones_routes <= atom_routes;
			tester_pkg::pa_trig_set:
				if (pwdata == 8'd1)
					cfg.pa_trig_set <= atom_routes;
			tester_pkg::pa_trig_reset:
				if (pwdata == 8'd1)
					cfg.pa_trig_reset <= atom_routes;
			tester_pkg::cmp_load: begin
				if (pwdata[0])
					cfg.cmp_value <= atom[tester_pkg::sample_width-1:0];
				if (pwdata[1])
					cfg.cmp_mask <= atom[tester_pkg::sample_width-1:0];
			end
			tester_pkg::cmp_trig:
				if (pwdata[0])
					cfg.cmp_routes <= atom_routes;
			default: ;
			endcase
		end
	end

	// pulses live only in the access cycle of the write.
	always_comb begin
		pa_cmd    = '0;
		irq_clear = '0;
		if (wr_en && addr == tester_pkg::pa_set)
			pa_cmd.set_mask = pwdata;
		if (wr_en && addr == tester_pkg::pa_reset)
			pa_cmd.reset_mask = pwdata;
		if (wr_en && addr == tester_pkg::irq_flags)
			irq_clear = pwdata[tester_pkg::num_routes-1:0]; // write one to clear.
	end

endmodule

//--- hw/tester_top.sv
`timescale 1ns/1ps

module tester_top (
	input  logic                                cpuclk,
	input  logic                                f_reset,
	input  logic                                psel,
	input  logic                                penable,
	input  logic                                pwrite,
	input  logic [tester_pkg::paddr_width-1:0] paddr,
	input  logic [tester_pkg::pdata_width-1:0] pwdata,
	output logic [tester_pkg::pdata_width-1:0] prdata,
	output logic                                pready,
	output logic                                pslverr,
	input  tester_pkg::dut_bus_t                dut_bus,
	output logic [tester_pkg::pa_width-1:0]    pa,
	output logic                                irq
);

	tester_pkg::tester_cfg_t cfg;
	tester_pkg::pa_cmd_t     pa_cmd;
	tester_pkg::route_t      irq_clear;
	tester_pkg::route_t      route;
	tester_pkg::route_t      irq_flags;
	tester_pkg::dut_bus_t    sample;
	logic                    match;

	tester_regs u_regs (
		.cpuclk    (cpuclk),
		.f_reset   (f_reset),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.sample    (sample),
		.irq_flags (irq_flags),
		.pa        (pa),
		.cfg       (cfg),
		.pa_cmd    (pa_cmd),
		.irq_clear (irq_clear)
	);

	bus_watch u_watch (
		.cpuclk  (cpuclk),
		.f_reset (f_reset),
		.dut_bus (dut_bus),
		.cfg     (cfg),
		.sample  (sample),
		.match   (match)
	);

	trigger_router u_router (
		.cpuclk    (cpuclk),
		.f_reset   (f_reset),
		.cfg       (cfg),
		.match     (match),
		.irq_clear (irq_clear),
		.route     (route),
		.irq_flags (irq_flags),
		.irq       (irq)
	);

	port_a_driver u_port (
		.cpuclk  (cpuclk),
		.f_reset (f_reset),
		.pa_cmd  (pa_cmd),
		.route   (route),
		.cfg     (cfg),
		.pa      (pa)
	);

endmodule

//--- hw/trigger_router.sv
`timescale 1ns/1ps

module trigger_router (
	input  logic                    cpuclk,
	input  logic                    f_reset,
	input  tester_pkg::tester_cfg_t cfg,
	input  logic                    match,
	input  tester_pkg::route_t      irq_clear,
	output tester_pkg::route_t      route,
	output tester_pkg::route_t      irq_flags,
	output logic                    irq
);

	tester_pkg::route_t cmp_hit;

	assign cmp_hit = match ? cfg.cmp_routes : '0;
	assign route   = cfg.ones_routes | cmp_hit;

	// an active route beats a clear of its sticky flag.
	always_ff @(posedge cpuclk) begin
		if (f_reset)
			irq_flags <= '0;
		else
			irq_flags <= (irq_flags & ~irq_clear) | route;
	end

	assign irq = |irq_flags;

endmodule

//--- sim/tb_tester.sv
`timescale 1ns/1ps

module tb_tester;

	localparam int period        = 20;
	localparam int reset_cycles  = 8;
	localparam int access_cycles = 3;
	localparam int max_accesses  = 96; // upper bound over the five tests.
	localparam int wait_cycles   = 16;
	localparam int margin_cycles = 100;
	localparam int timeout_ns    =
		period * (reset_cycles + access_cycles * max_accesses + wait_cycles + margin_cycles);

	logic                                cpuclk;
	logic                                f_reset;
	logic                                psel;
	logic                                penable;
	logic                                pwrite;
	logic [tester_pkg::paddr_width-1:0] paddr;
	logic [tester_pkg::pdata_width-1:0] pwdata;
	logic [tester_pkg::pdata_width-1:0] prdata;
	logic                                pready;
	logic                                pslverr;
	tester_pkg::dut_bus_t                dut_bus;
	logic [tester_pkg::pa_width-1:0]    pa;
	logic                                irq;

	int errors;
	int checks;
	int tests;
	int errors_base;
	int checks_base;

	tester_top u_dut (
		.cpuclk  (cpuclk),
		.f_reset (f_reset),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.dut_bus (dut_bus),
		.pa      (pa),
		.irq     (irq)
	);

	initial begin
		cpuclk = 1'b0;
		forever #(period / 2) cpuclk = ~cpuclk;
	end

	initial begin
		#(timeout_ns);
		$display("watchdog expired before the tests finished");
		$display("Errors found");
		$finish;
	end

	task automatic check_byte(input string name, input logic [tester_pkg::pdata_width-1:0] got,
			input logic [tester_pkg::pdata_width-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_routes(input string name, input tester_pkg::route_t got,
			input tester_pkg::route_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	// setup edge, access edge, then sample at the falling edge while pready is high.
	task automatic apb_access(input logic write, input logic [7:0] addr,
			input logic [7:0] wdata, output logic [7:0] rdata, output logic err);
		int waited;
		waited = 0;
		@(posedge cpuclk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= write;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge cpuclk);
		penable <= 1'b1;
		@(negedge cpuclk);
		while (pready !== 1'b1 && waited < wait_cycles) begin
			@(negedge cpuclk);
			waited++;
		end
		if (pready !== 1'b1) begin
			errors++;
			$display("apb access to offset 0x%h never saw pready", addr);
		end
		rdata = prdata;
		err   = pslverr;
		@(posedge cpuclk);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [7:0] data);
		logic [7:0] rd;
		logic       err;
		apb_access(1'b1, addr, data, rd, err);
		check_flag("pslverr", err, 1'b0);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [7:0] data, output logic err);
		apb_access(1'b0, addr, 8'h00, data, err);
	endtask

	task automatic load_atom(input logic [31:0] value);
		for (int i = 0; i < 4; i++)
			apb_write(8'(tester_pkg::atom0 + i), value[8*i +: 8]);
	endtask

	task automatic begin_test();
		errors_base = errors;
		checks_base = checks;
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("test %0d %s: %0d checks, %0d errors", tests, name,
			checks - checks_base, errors - errors_base);
	endtask

	task automatic reset_values();
		tester_pkg::reg_addr_e a;
		logic [7:0]            rd;
		logic                  err;
		begin_test();
		a = a.first();
		do begin
			apb_read(a, rd, err);
			check_byte(a.name(), rd, 8'h00);
			check_flag("pslverr", err, 1'b0);
			a = a.next();
		end while (a != a.first());
		@(negedge cpuclk);
		check_flag("irq", irq, 1'b0);
		check_byte("pa", pa, 8'h00);
		apb_read(8'h40, rd, err); // unmapped.
		check_flag("pslverr", err, 1'b1);
		finish_test("reset values");
	endtask

	task automatic atom_bytes();
		logic [7:0] value [4];
		logic [7:0] rd;
		logic       err;
		begin_test();
		foreach (value[i]) begin
			value[i] = 8'($urandom);
			apb_write(8'(tester_pkg::atom0 + i), value[i]);
		end
		foreach (value[i]) begin
			apb_read(8'(tester_pkg::atom0 + i), rd, err);
			check_byte($sformatf("atom%0d", i), rd, value[i]);
		end
		finish_test("atom bytes");
	endtask

	task automatic port_a_masks();
		logic [7:0] set_bits;
		logic [7:0] rst_bits;
		logic [7:0] rd;
		logic       err;
		begin_test();
		set_bits = 8'($urandom) | 8'h80;
		rst_bits = 8'($urandom) | 8'h81; // overlap on bit 7 and bit 0 ends low.
		apb_write(tester_pkg::pa_set, set_bits);
		apb_write(tester_pkg::pa_reset, rst_bits);
		@(negedge cpuclk);
		check_byte("pa", pa, set_bits & ~rst_bits);
		apb_read(tester_pkg::pa_out, rd, err);
		check_byte("pa_out", rd, set_bits & ~rst_bits);
		finish_test("port a masks");
	endtask

	task automatic ones_route();
		logic [7:0] rd;
		logic       err;
		begin_test();
		apb_write(tester_pkg::atom0, 8'h04);
		apb_write(tester_pkg::ones_set, 8'h00);
		@(posedge cpuclk);
		@(negedge cpuclk);
		check_flag("irq", irq, 1'b1);
		apb_read(tester_pkg::irq_flags, rd, err);
		check_routes("irq_flags", tester_pkg::route_t'(rd), 4'b0100);
		apb_write(tester_pkg::irq_flags, 8'h04);
		apb_read(tester_pkg::irq_flags, rd, err);
		check_routes("irq_flags", tester_pkg::route_t'(rd), 4'b0100); // route still holds.
		apb_write(tester_pkg::atom0, 8'h00);
		apb_write(tester_pkg::ones_set, 8'h00);
		apb_write(tester_pkg::irq_flags, 8'h04);
		apb_read(tester_pkg::irq_flags, rd, err);
		check_routes("irq_flags", tester_pkg::route_t'(rd), 4'b0000);
		@(negedge cpuclk);
		check_flag("irq", irq, 1'b0);
		finish_test("ones route");
	endtask

	task automatic compare_route();
		logic [31:0]                         word;
		logic [tester_pkg::sample_width-1:0] value;
		logic [tester_pkg::sample_width-1:0] mask;
		logic [tester_pkg::sample_width-1:0] flipped;
		logic [7:0]                          rd;
		logic                                err;
		begin_test();
		word    = $urandom;
		value   = word[tester_pkg::sample_width-1:0];
		word    = $urandom;
		mask    = word[tester_pkg::sample_width-1:0];
		mask[5] = 1'b1;
		mask[6] = 1'b0;
		@(posedge cpuclk);
		dut_bus <= tester_pkg::dut_bus_t'(value);
		load_atom(32'(value));
		apb_write(tester_pkg::cmp_load, 8'h01);
		load_atom(32'(mask));
		apb_write(tester_pkg::cmp_load, 8'h02);
		apb_write(tester_pkg::atom0, 8'h02); // route 1.
		apb_write(tester_pkg::pa_trig_set, 8'h01);
		apb_write(tester_pkg::cmp_trig, 8'h01);
		@(posedge cpuclk);
		@(negedge cpuclk);
		check_flag("pa[0]", pa[0], 1'b1);
		check_flag("irq", irq, 1'b1);
		apb_read(tester_pkg::irq_flags, rd, err);
		check_routes("irq_flags", tester_pkg::route_t'(rd), 4'b0010);
		word = 32'(value);
		for (int i = 0; i < 4; i++) begin
			apb_read(8'(tester_pkg::sample0 + i), rd, err);
			check_byte($sformatf("sample%0d", i), rd, word[8*i +: 8]);
		end
		flipped    = value;
		flipped[6] = ~flipped[6];
		@(posedge cpuclk);
		dut_bus <= tester_pkg::dut_bus_t'(flipped);
		repeat (2) @(posedge cpuclk);
		apb_write(tester_pkg::irq_flags, 8'h02);
		apb_read(tester_pkg::irq_flags, rd, err);
		check_routes("irq_flags", tester_pkg::route_t'(rd), 4'b0010); // unmasked bit keeps the match.
		flipped[5] = ~flipped[5];
		@(posedge cpuclk);
		dut_bus <= tester_pkg::dut_bus_t'(flipped);
		repeat (2) @(posedge cpuclk);
		apb_write(tester_pkg::irq_flags, 8'h02);
		apb_read(tester_pkg::irq_flags, rd, err);
		check_routes("irq_flags", tester_pkg::route_t'(rd), 4'b0000);
		@(negedge cpuclk);
		check_flag("irq", irq, 1'b0);
		finish_test("compare route");
	endtask

	initial begin
		void'($urandom(9501));
		errors  = 0;
		checks  = 0;
		tests   = 0;
		f_reset = 1'b1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		dut_bus = '0;
		repeat (reset_cycles) @(posedge cpuclk);
		f_reset <= 1'b0;
		reset_values();
		atom_bytes();
		port_a_masks();
		ones_route();
		compare_route();
		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
			tests, checks, errors, u_dut.u_sva.violations);
		if (errors == 0 && u_dut.u_sva.violations == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- sim/tester_sva.sv
`timescale 1ns/1ps

module tester_sva (
	input logic                             cpuclk,
	input logic                             f_reset,
	input logic                             psel,
	input logic                             penable,
	input logic                             pready,
	input logic                             pslverr,
	input logic [tester_pkg::pa_width-1:0] pa
);

	int violations = 0; // failed assertions so far.

	pready_high: assert property (@(posedge cpuclk) disable iff (f_reset) pready)
		else begin
			violations++;
			$error("pready went low");
		end

	// an error response only exists in the access phase.
	pslverr_in_access: assert property (@(posedge cpuclk) disable iff (f_reset)
			pslverr |-> psel && penable)
		else begin
			violations++;
			$error("pslverr outside the access phase");
		end

	pa_after_reset: assert property (@(posedge cpuclk) f_reset |=> pa == '0)
		else begin
			violations++;
			$error("pa not zero after reset");
		end

endmodule

bind tester_top tester_sva u_sva (
	.cpuclk  (cpuclk),
	.f_reset (f_reset),
	.psel    (psel),
	.penable (penable),
	.pready  (pready),
	.pslverr (pslverr),
	.pa      (pa)
);

//--- tester.f
hw/tester_pkg.sv
hw/tester_regs.sv
hw/bus_watch.sv
hw/trigger_router.sv
hw/port_a_driver.sv
hw/tester_top.sv
sim/tester_sva.sv
sim/tb_tester.sv
